// File: tb.f
+incdir+hw
hw/mem_pkg.sv
hw/banked_mem_core.sv
hw/stream_cmd_ctrl.sv
hw/mem_sys_top.sv
dv/mem_properties.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

exit 0

// File: dv/tb_top.sv
`include "mem_settings.svh"

module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 6;

  logic clock;
  logic reset_i;
  logic s_valid_i;
  logic s_ready_o;
  logic s_last_i;
  logic [7:0] s_data_i;
  logic m_valid_o;
  logic m_ready_i;
  logic m_last_o;
  logic [7:0] m_data_o;

  int test_num;
  logic test_end;
  logic report;
  logic pending;
  int fail_cnt;

  logic [31:0] rng_s = 32'd21;
  logic [31:0] rdy_s = 32'd21;
  int gap_pct;
  int stall_pct;
  int cycles;
  int limit;

  int cq_op [$];
  int cq_addr [$];
  int cq_len [$];
  int cq_test [$];

  mem_sys_top DUT (
    .clock(clock), .reset_i(reset_i),
    .s_valid_i(s_valid_i), .s_ready_o(s_ready_o), .s_last_i(s_last_i), .s_data_i(s_data_i),
    .m_valid_o(m_valid_o), .m_ready_i(m_ready_i), .m_last_o(m_last_o), .m_data_o(m_data_o)
  );

  tb_checker checker_inst (
    .clock(clock), .reset_i(reset_i),
    .s_valid_i(s_valid_i), .s_ready_i(s_ready_o), .s_last_i(s_last_i), .s_data_i(s_data_i),
    .m_valid_i(m_valid_o), .m_ready_i(m_ready_i), .m_last_i(m_last_o), .m_data_i(m_data_o),
    .test_num_i(test_num), .test_end_i(test_end), .report_i(report),
    .pending_o(pending), .fail_cnt_o(fail_cnt)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int rand_below(input int n);
    rng_s = lcg_step(rng_s);
    return int'(rng_s[30:8]) % n;
  endfunction

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    rdy_s <= lcg_step(rdy_s);
    m_ready_i <= (int'(rdy_s[30:8]) % 100) >= stall_pct;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the DUT did not finish all commands within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic add_cmd(input int op, input int addr, input int len, input int t);
    cq_op.push_back(op);
    cq_addr.push_back(addr % 512);
    cq_len.push_back(len);
    cq_test.push_back(t);
  endtask

  task automatic add_pair(input int addr, input int len, input int t);
    add_cmd(1, addr, len, t);
    add_cmd(2, addr, len, t);
  endtask

  // Returns at the rising edge where the byte transferred
  task automatic send_byte(input logic [7:0] b, input logic last);
    logic ok;
    while (rand_below(100) < gap_pct) begin
      s_valid_i <= 1'b0;
      @(posedge clock);
    end
    s_valid_i <= 1'b1;
    s_data_i <= b;
    s_last_i <= last;
    do begin
      @(negedge clock);
      ok = s_ready_o;
      @(posedge clock);
    end while (!ok);
  endtask

  task automatic send_cmd(input int i);
    int n;
    n = cq_len[i];
    if (cq_op[i] == 1 || cq_op[i] == 2) begin
      send_byte(8'(cq_op[i]), 1'b0);
      send_byte(8'(cq_addr[i]), 1'b0);
      // Upper address and length bits are ignored by the DUT
      send_byte({7'(rand_below(128)), 1'(cq_addr[i] >> 8)}, 1'b0);
      send_byte({4'(rand_below(16)), 4'(n - 1)}, cq_op[i] == 2);
      if (cq_op[i] == 1) begin
        for (int k = 0; k < 4 * n; k++) begin
          send_byte(8'(rand_below(256)), k == 4 * n - 1);
        end
      end
    end else begin
      send_byte(8'(cq_op[i]), n == 0);
      for (int k = 0; k < n; k++) begin
        send_byte(8'(rand_below(256)), k == n - 1);
      end
    end
  endtask

  task automatic build_commands();
    int op;
    add_cmd(2, 100, 8, 0);
    add_cmd(2, 300, 4, 0);
    add_pair(rand_below(512), 1, 1);
    for (int k = 0; k < 6; k++) begin
      add_pair(rand_below(512), rand_below(16) + 1, 2);
    end
    add_pair(505, 16, 2);
    // Alternating rows in bank 2 and then a burst across a bank edge
    for (int r = 0; r < 6; r++) begin
      add_cmd(1, (r << 6) | (2 << 4) | 3, 2, 3);
    end
    for (int r = 0; r < 3; r++) begin
      add_cmd(2, ((5 - r) << 6) | (2 << 4) | 3, 2, 3);
      add_cmd(2, (r << 6) | (2 << 4) | 3, 2, 3);
    end
    add_pair(14, 6, 3);
    add_cmd(2, (6 << 6) | (3 << 4), 3, 3);
    for (int k = 0; k < 5; k++) begin
      add_pair(rand_below(512), rand_below(16) + 1, 4);
    end
    op = rand_below(256);
    if (op == 1 || op == 2) begin
      op = 8'h7F;
    end
    add_cmd(op, 0, rand_below(7), 5);
    add_cmd(8'hFF, 0, 0, 5);
    add_pair(rand_below(512), rand_below(16) + 1, 5);
  endtask

  function automatic int timeout_limit();
    int stim;
    int resp;
    stim = 0;
    resp = 0;
    for (int i = 0; i < cq_op.size(); i++) begin
      if (cq_op[i] == 1) begin
        stim += 4 + 4 * cq_len[i];
        resp += 1;
      end else if (cq_op[i] == 2) begin
        stim += 4;
        resp += 4 * cq_len[i];
      end else begin
        stim += 1 + cq_len[i];
        resp += 1;
      end
    end
    return stim + 4 * resp + cq_op.size() * 16 * (`MEM_ACT_CYCLES + 2) + 1000;
  endfunction

  initial begin
    int next;
    int prop_errs;
    reset_i = 1'b1;
    s_valid_i = 1'b0;
    s_last_i = 1'b0;
    s_data_i = 8'h00;
    m_ready_i = 1'b0;
    test_num = 0;
    test_end = 1'b0;
    report = 1'b0;
    gap_pct = 10;
    stall_pct = 10;
    cycles = 0;
    build_commands();
    limit = timeout_limit();
    repeat (10) @(posedge clock);
    reset_i <= 1'b0;
    @(posedge clock);
    next = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_num <= t;
      gap_pct = (t == 4) ? 50 : 10;
      stall_pct = (t == 4) ? 60 : 10;
      while (next < cq_op.size() && cq_test[next] == t) begin
        send_cmd(next);
        next++;
      end
      s_valid_i <= 1'b0;
      s_last_i <= 1'b0;
      do begin
        @(negedge clock);
      end while (pending);
      @(posedge clock);
      test_end <= 1'b1;
      @(posedge clock);
      test_end <= 1'b0;
    end
    report <= 1'b1;
    @(posedge clock);
    report <= 1'b0;
    @(posedge clock);
    prop_errs = DUT.core_inst.rbeat_props.fails + DUT.ctrl_inst.req_props.fails
                + DUT.ctrl_inst.wbeat_props.fails + DUT.ctrl_inst.out_props.fails;
    if (fail_cnt == 0 && prop_errs == 0) begin
      $display("Simulation passed");
    end else begin
      if (prop_errs != 0) begin
        $display("%0d handshake or reset assertions failed", prop_errs);
      end
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: dv/tb_checker.sv
module tb_checker (
  input  logic       clock,
  input  logic       reset_i,
  input  logic       s_valid_i,
  input  logic       s_ready_i,
  input  logic       s_last_i,
  input  logic [7:0] s_data_i,
  input  logic       m_valid_i,
  input  logic       m_ready_i,
  input  logic       m_last_i,
  input  logic [7:0] m_data_i,
  input  int         test_num_i,
  input  logic       test_end_i,
  input  logic       report_i,
  output logic       pending_o,
  output int         fail_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] model_mem [512];
  logic [8:0] exp_q [$];

  int pidx;
  logic bad_op;
  logic is_write;
  logic [8:0] paddr;
  int plen;
  int wbytes;
  logic [31:0] wword;
  int test_errs;
  int pass_cnt;

  function automatic string test_name(input int n);
    case (n)
      0: return "reset_zero_read";
      1: return "single_word";
      2: return "random_bursts";
      3: return "row_misses";
      4: return "back_pressure";
      5: return "invalid_opcode";
      default: return "unknown";
    endcase
  endfunction

  // Builds expected response bytes from each input byte, {last, data}
  task automatic parse_byte(input logic [7:0] b, input logic last);
    logic [31:0] w;
    logic [8:0] a;
    if (pidx == 0) begin
      bad_op = (b != 8'h01) && (b != 8'h02);
      is_write = (b == 8'h01);
      wbytes = 0;
    end else if (!bad_op && pidx == 1) begin
      paddr[7:0] = b;
    end else if (!bad_op && pidx == 2) begin
      paddr[8] = b[0];
    end else if (!bad_op && pidx == 3) begin
      plen = int'(b[3:0]) + 1;
      if (!is_write) begin
        for (int k = 0; k < plen; k++) begin
          a = paddr + 9'(k);
          w = model_mem[a];
          for (int j = 0; j < 4; j++) begin
            exp_q.push_back({(k == plen - 1 && j == 3), w[8*j +: 8]});
          end
        end
      end
    end else if (!bad_op) begin
      wword[8*(wbytes % 4) +: 8] = b;
      wbytes++;
      if (wbytes % 4 == 0) begin
        a = paddr + 9'(wbytes / 4 - 1);
        model_mem[a] = wword;
        if (wbytes == 4 * plen) begin
          exp_q.push_back({1'b1, 8'h00});
        end
      end
    end
    pidx++;
    if (last) begin
      if (bad_op) begin
        exp_q.push_back({1'b1, 8'hFF});
      end
      pidx = 0;
    end
  endtask

  always @(posedge clock) begin
    logic [8:0] exp_b;
    if (reset_i) begin
      for (int i = 0; i < 512; i++) begin
        model_mem[i] = '0;
      end
      exp_q.delete();
      pidx = 0;
      test_errs = 0;
      pass_cnt = 0;
      fail_cnt_o <= 0;
      pending_o <= 1'b0;
    end else begin
      if (s_valid_i && s_ready_i) begin
        parse_byte(s_data_i, s_last_i);
      end
      if (m_valid_i && m_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Test %s: the DUT sent an output byte that was not expected",
                   test_name(test_num_i));
          test_errs++;
        end else begin
          exp_b = exp_q.pop_front();
          if (exp_b != {m_last_i, m_data_i}) begin
            $display("ERROR test %s: expected last,data %h actual %h",
                     test_name(test_num_i), exp_b, {m_last_i, m_data_i});
            test_errs++;
          end
        end
      end
      if (test_end_i) begin
        if (test_errs == 0) begin
          pass_cnt++;
          $display("Test %0d %s: PASS", test_num_i, test_name(test_num_i));
        end else begin
          fail_cnt_o <= fail_cnt_o + 1;
          $display("Test %0d %s: FAIL, %0d errors", test_num_i, test_name(test_num_i),
                   test_errs);
        end
        test_errs = 0;
      end
      if (report_i) begin
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt_o);
      end
      pending_o <= (exp_q.size() != 0);
    end
  end

endmodule

// File: dv/mem_properties.sv
module mem_properties #(
  parameter int W = 8
) (
  input logic         clock,
  input logic         reset_i,
  input logic         valid,
  input logic         ready,
  input logic [W-1:0] payload
);

  timeunit 1ns;
  timeprecision 100ps;

  int fails = 0;

  // Valid holds with a stable payload until the transfer
  hold_until_ready: assert property (
    @(posedge clock) disable iff (reset_i)
    valid && !ready |=> valid && $stable(payload)
  ) else begin
    $error("valid dropped or payload changed before ready");
    fails++;
  end

  // First cycle out of reset
  low_after_reset: assert property (
    @(posedge clock) $fell(reset_i) |-> !valid
  ) else begin
    $error("valid high in the cycle after reset");
    fails++;
  end

  quiet_in_reset: assert property (
    @(posedge clock) $past(reset_i) && reset_i |-> !valid
  ) else begin
    $error("valid high while reset is held");
    fails++;
  end

endmodule

bind banked_mem_core mem_properties #(.W(33)) rbeat_props (
  .clock(clock), .reset_i(reset_i),
  .valid(rbeat_valid_o), .ready(rbeat_ready_i), .payload(rbeat_o)
);

bind stream_cmd_ctrl mem_properties #(.W(14)) req_props (
  .clock(clock), .reset_i(reset_i),
  .valid(req_valid_o), .ready(req_ready_i), .payload(req_o)
);

bind stream_cmd_ctrl mem_properties #(.W(33)) wbeat_props (
  .clock(clock), .reset_i(reset_i),
  .valid(wbeat_valid_o), .ready(wbeat_ready_i), .payload(wbeat_o)
);

bind stream_cmd_ctrl mem_properties #(.W(9)) out_props (
  .clock(clock), .reset_i(reset_i),
  .valid(m_valid_o), .ready(m_ready_i), .payload({m_last_o, m_data_o})
);

// File: hw/mem_sys_top.sv
module mem_sys_top (
  input  logic       clock,
  input  logic       reset_i,

  input  logic       s_valid_i,
  output logic       s_ready_o,
  input  logic       s_last_i,
  input  logic [7:0] s_data_i,

  output logic       m_valid_o,
  input  logic       m_ready_i,
  output logic       m_last_o,
  output logic [7:0] m_data_o
);

  mem_pkg::mem_req_t req;
  logic req_valid;
  logic req_ready;

  mem_pkg::mem_wbeat_t wbeat;
  logic wbeat_valid;
  logic wbeat_ready;

  mem_pkg::mem_rbeat_t rbeat;
  logic rbeat_valid;
  logic rbeat_ready;

  // Byte-stream command front end
  stream_cmd_ctrl ctrl_inst (
    .clock        (clock),
    .reset_i      (reset_i),
    .s_valid_i    (s_valid_i),
    .s_ready_o    (s_ready_o),
    .s_last_i     (s_last_i),
    .s_data_i     (s_data_i),
    .m_valid_o    (m_valid_o),
    .m_ready_i    (m_ready_i),
    .m_last_o     (m_last_o),
    .m_data_o     (m_data_o),
    .req_o        (req),
    .req_valid_o  (req_valid),
    .req_ready_i  (req_ready),
    .wbeat_o      (wbeat),
    .wbeat_valid_o(wbeat_valid),
    .wbeat_ready_i(wbeat_ready),
    .rbeat_i      (rbeat),
    .rbeat_valid_i(rbeat_valid),
    .rbeat_ready_o(rbeat_ready)
  );

  // Banked memory model
  banked_mem_core core_inst (
    .clock        (clock),
    .reset_i      (reset_i),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .wbeat_i      (wbeat),
    .wbeat_valid_i(wbeat_valid),
    .wbeat_ready_o(wbeat_ready),
    .rbeat_o      (rbeat),
    .rbeat_valid_o(rbeat_valid),
    .rbeat_ready_i(rbeat_ready)
  );

endmodule

// File: hw/stream_cmd_ctrl.sv
`include "mem_settings.svh"

module stream_cmd_ctrl (
  input  logic                clock,
  input  logic                reset_i,

  input  logic                s_valid_i,
  output logic                s_ready_o,
  input  logic                s_last_i,
  input  logic [7:0]          s_data_i,

  output logic                m_valid_o,
  input  logic                m_ready_i,
  output logic                m_last_o,
  output logic [7:0]          m_data_o,

  output mem_pkg::mem_req_t   req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i,

  output mem_pkg::mem_wbeat_t wbeat_o,
  output logic                wbeat_valid_o,
  input  logic                wbeat_ready_i,

  input  mem_pkg::mem_rbeat_t rbeat_i,
  input  logic                rbeat_valid_i,
  output logic                rbeat_ready_o
);

  localparam int LEN_BITS = $clog2(`MEM_MAX_BURST);
  localparam logic [7:0] STATUS_OK = 8'h00;
  localparam logic [7:0] STATUS_BAD = 8'hFF;

  mem_pkg::ctrl_state_e state_q;
  mem_pkg::cmd_op_e op_q;
  mem_pkg::cmd_op_e op_in;

  logic [`MEM_WORD_ADDR_BITS-1:0] addr_q;
  logic [LEN_BITS-1:0] len_q;
  logic [LEN_BITS-1:0] beat_cnt_q;
  logic [1:0] byte_cnt_q;
  logic req_valid_q;
  logic [31:0] wdata_q;
  logic wlast_q;
  logic wvalid_q;
  logic [31:0] rdata_q;
  logic rlast_q;
  logic m_valid_q;
  logic [7:0] status_q;

  logic s_fire;
  logic m_fire;
  logic wbeat_fire;
  logic rbeat_fire;

  assign op_in = mem_pkg::cmd_op_e'(s_data_i);

  always_comb begin
    case (state_q)
      mem_pkg::OPCODE,
      mem_pkg::ADDR_LO,
      mem_pkg::ADDR_HI,
      mem_pkg::LEN,
      mem_pkg::DRAIN: s_ready_o = 1'b1;
      // One word buffer, refilled once the core takes it
      mem_pkg::WDATA: s_ready_o = !wvalid_q;
      default:        s_ready_o = 1'b0;
    endcase
  end

  assign s_fire = s_valid_i && s_ready_o;
  assign m_fire = m_valid_q && m_ready_i;
  assign wbeat_fire = wvalid_q && wbeat_ready_i;
  assign rbeat_fire = rbeat_valid_i && rbeat_ready_o;

  assign req_o.write = (op_q == mem_pkg::OP_WRITE);
  assign req_o.addr = addr_q;
  assign req_o.len = len_q;
  assign req_valid_o = req_valid_q;

  assign wbeat_o.data = wdata_q;
  assign wbeat_o.last = wlast_q;
  assign wbeat_valid_o = wvalid_q;

  // Next word only after all four bytes of the current one left
  assign rbeat_ready_o = (state_q == mem_pkg::WAIT_READ) && !m_valid_q;

  assign m_valid_o = m_valid_q;
  assign m_data_o = (state_q == mem_pkg::SEND_STATUS) ? status_q
                                                      : rdata_q[{byte_cnt_q, 3'b000} +: 8];
  assign m_last_o = (state_q == mem_pkg::SEND_STATUS) || (rlast_q && byte_cnt_q == 2'd3);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q     <= mem_pkg::OPCODE;
      op_q        <= mem_pkg::OP_READ;
      req_valid_q <= 1'b0;
      wvalid_q    <= 1'b0;
      wlast_q     <= 1'b0;
      rlast_q     <= 1'b0;
      m_valid_q   <= 1'b0;
      byte_cnt_q  <= '0;
      beat_cnt_q  <= '0;
      status_q    <= STATUS_OK;
    end else begin
      if (req_valid_q && req_ready_i) begin
        req_valid_q <= 1'b0;
      end
      if (wbeat_fire) begin
        wvalid_q <= 1'b0;
      end

      case (state_q)
        mem_pkg::OPCODE: begin
          if (s_fire) begin
            if (op_in == mem_pkg::OP_WRITE || op_in == mem_pkg::OP_READ) begin
              op_q    <= op_in;
              state_q <= mem_pkg::ADDR_LO;
            end else if (s_last_i) begin
              status_q  <= STATUS_BAD;
              m_valid_q <= 1'b1;
              state_q   <= mem_pkg::SEND_STATUS;
            end else begin
              state_q <= mem_pkg::DRAIN;
            end
          end
        end
        mem_pkg::ADDR_LO: begin
          if (s_fire) begin
            state_q <= mem_pkg::ADDR_HI;
          end
        end
        mem_pkg::ADDR_HI: begin
          if (s_fire) begin
            state_q <= mem_pkg::LEN;
          end
        end
        mem_pkg::LEN: begin
          if (s_fire) begin
            req_valid_q <= 1'b1;
            beat_cnt_q  <= s_data_i[LEN_BITS-1:0];
            byte_cnt_q  <= '0;
            state_q     <= (op_q == mem_pkg::OP_WRITE) ? mem_pkg::WDATA : mem_pkg::WAIT_READ;
          end
        end
        mem_pkg::WDATA: begin
          if (s_fire) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_cnt_q == 2'd3) begin
              wvalid_q   <= 1'b1;
              wlast_q    <= (beat_cnt_q == '0);
              beat_cnt_q <= beat_cnt_q - 1'b1;
            end
          end
          if (wbeat_fire && wlast_q) begin
            status_q  <= STATUS_OK;
            m_valid_q <= 1'b1;
            state_q   <= mem_pkg::SEND_STATUS;
          end
        end
        mem_pkg::WAIT_READ: begin
          if (rbeat_fire) begin
            m_valid_q  <= 1'b1;
            rlast_q    <= rbeat_i.last;
            byte_cnt_q <= '0;
          end
          if (m_fire) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_cnt_q == 2'd3) begin
              m_valid_q <= 1'b0;
              if (rlast_q) begin
                rlast_q <= 1'b0;
                state_q <= mem_pkg::OPCODE;
              end
            end
          end
        end
        mem_pkg::SEND_STATUS: begin
          if (m_fire) begin
            m_valid_q <= 1'b0;
            state_q   <= mem_pkg::OPCODE;
          end
        end
        mem_pkg::DRAIN: begin
          // Swallow the rest of a bad packet
          if (s_fire && s_last_i) begin
            status_q  <= STATUS_BAD;
            m_valid_q <= 1'b1;
            state_q   <= mem_pkg::SEND_STATUS;
          end
        end
        default: state_q <= mem_pkg::OPCODE;
      endcase
    end
  end

  // Command fields and data words
  always_ff @(posedge clock) begin
    if (s_fire) begin
      case (state_q)
        mem_pkg::ADDR_LO: addr_q[7:0] <= s_data_i;
        mem_pkg::ADDR_HI: addr_q[`MEM_WORD_ADDR_BITS-1:8] <= s_data_i[`MEM_WORD_ADDR_BITS-9:0];
        mem_pkg::LEN:     len_q <= s_data_i[LEN_BITS-1:0];
        mem_pkg::WDATA:   wdata_q[{byte_cnt_q, 3'b000} +: 8] <= s_data_i;
        default: ;
      endcase
    end
    if (rbeat_fire) begin
      rdata_q <= rbeat_i.data;
    end
  end

endmodule

// File: hw/banked_mem_core.sv
`include "mem_settings.svh"

module banked_mem_core (
  input  logic                clock,
  input  logic                reset_i,

  input  mem_pkg::mem_req_t   req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,

  input  mem_pkg::mem_wbeat_t wbeat_i,
  input  logic                wbeat_valid_i,
  output logic                wbeat_ready_o,

  output mem_pkg::mem_rbeat_t rbeat_o,
  output logic                rbeat_valid_o,
  input  logic                rbeat_ready_i
);

  localparam int WORDS = 1 << `MEM_WORD_ADDR_BITS;
  localparam int BANKS = 1 << `MEM_BANK_BITS;
  localparam int LEN_BITS = $clog2(`MEM_MAX_BURST);
  localparam int ACT_BITS = $clog2(`MEM_ACT_CYCLES + 1);

  logic [31:0] mem [WORDS];

  logic busy_q;
  logic write_q;
  logic [`MEM_WORD_ADDR_BITS-1:0] addr_q;
  logic [LEN_BITS-1:0] remain_q;
  logic [ACT_BITS-1:0] act_cnt_q;

  // Open row per bank, with its valid bit
  logic [`MEM_ROW_BITS-1:0] open_row_q [BANKS];
  logic [BANKS-1:0] row_open_q;

  mem_pkg::mem_rbeat_t rbeat_q;
  logic rvalid_q;

  logic [`MEM_COL_BITS-1:0] col;
  logic [`MEM_BANK_BITS-1:0] bank;
  logic [`MEM_ROW_BITS-1:0] row;
  logic [`MEM_WORD_ADDR_BITS-1:0] word_idx;
  logic row_hit;
  logic act_done;
  logic wr_fire;
  logic rd_fire;
  logic beat_done;
  logic last_beat;

  assign col = addr_q[`MEM_COL_BITS-1:0];
  assign bank = addr_q[`MEM_COL_BITS +: `MEM_BANK_BITS];
  assign row = addr_q[`MEM_WORD_ADDR_BITS-1 -: `MEM_ROW_BITS];
  assign word_idx = {row, bank, col};

  assign row_hit = row_open_q[bank] && (open_row_q[bank] == row);

  // Last activate cycle of a miss
  assign act_done = busy_q && !row_hit && (act_cnt_q == ACT_BITS'(`MEM_ACT_CYCLES - 1));

  assign req_ready_o = !busy_q;
  assign wbeat_ready_o = busy_q && write_q && row_hit;
  assign wr_fire = wbeat_ready_o && wbeat_valid_i;

  // Fetch only into a free output slot, or one being emptied this cycle
  assign rd_fire = busy_q && !write_q && row_hit && (!rvalid_q || rbeat_ready_i);

  assign beat_done = wr_fire || rd_fire;
  assign last_beat = write_q ? wbeat_i.last : (remain_q == '0);

  assign rbeat_o = rbeat_q;
  assign rbeat_valid_o = rvalid_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      write_q    <= 1'b0;
      addr_q     <= '0;
      remain_q   <= '0;
      act_cnt_q  <= '0;
      row_open_q <= '0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        busy_q   <= 1'b1;
        write_q  <= req_i.write;
        addr_q   <= req_i.addr;
        remain_q <= req_i.len;
      end
      if (busy_q && !row_hit) begin
        act_cnt_q <= act_done ? '0 : act_cnt_q + 1'b1;
      end
      if (act_done) begin
        row_open_q[bank] <= 1'b1;
      end
      if (beat_done) begin
        addr_q   <= addr_q + 1'b1;
        remain_q <= remain_q - 1'b1;
        if (last_beat) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (act_done) begin
      open_row_q[bank] <= row;
    end
  end

  // Array starts out as zeros
  always_ff @(posedge clock) begin
    if (reset_i) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_fire) begin
      mem[word_idx] <= wbeat_i.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (rbeat_ready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rbeat_q.data <= mem[word_idx];
      rbeat_q.last <= (remain_q == '0);
    end
  end

endmodule

// File: hw/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

  // First byte of every command packet
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } cmd_op_e;

  // Command parser and response FSM
  typedef enum logic [2:0] {
    OPCODE,
    ADDR_LO,
    ADDR_HI,
    LEN,
    WDATA,
    WAIT_READ,
    SEND_STATUS,
    DRAIN
  } ctrl_state_e;

  // One request per command, len holds burst length minus one
  typedef struct packed {
    logic                               write;
    logic [`MEM_WORD_ADDR_BITS-1:0]     addr;
    logic [$clog2(`MEM_MAX_BURST)-1:0]  len;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } mem_wbeat_t;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } mem_rbeat_t;

endpackage

// File: hw/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Word address of the on-chip array, 512 words of 32 bits
`define MEM_WORD_ADDR_BITS 9

// Address split, low to high: column, bank, row
`define MEM_COL_BITS 4
`define MEM_BANK_BITS 2
`define MEM_ROW_BITS 3

// Longest burst one command may ask for
`define MEM_MAX_BURST 16

// Activate penalty paid by a beat that misses its open row
`define MEM_ACT_CYCLES 3

`endif
